/* sdram_params.svh */
`ifndef SDRAM_PARAMS_SVH
`define SDRAM_PARAMS_SVH

// ----------------------------------------------------------------------
// Field widths
// ----------------------------------------------------------------------
`define SDRAM_ADDR_W    26       // Request address
`define SDRAM_ROW_W     14       // Row, also command address bus
`define SDRAM_BANK_W    3
`define SDRAM_COL_W     9
`define SDRAM_DM_W      4        // Write mask

// Request address layout is row | bank | column
`define SDRAM_ROW_LSB   12
`define SDRAM_BANK_LSB  9

// ----------------------------------------------------------------------
// Command spacing, in controller clocks
// ----------------------------------------------------------------------
`define SDRAM_T_RP      3        // PRCH to next, also post-reset wait
`define SDRAM_T_RCD     3        // ACTV to next
`define SDRAM_T_RW      2        // READ/WRTE to next
`define SDRAM_T_RFC     12       // ARSR to next
`define SDRAM_T_RAS     6        // ACTV to PRCH

// A10 set selects all banks
`define SDRAM_PRCH_ALL  14'h0400

`endif

/* sdram_pkg.sv */
`include "sdram_params.svh"

package sdram_pkg;

  // Opcodes as driven on {RAS#, CAS#, WE#}
  typedef enum logic [2:0] {
    MRST = 3'b000,
    ARSR = 3'b001,
    PRCH = 3'b010,
    ACTV = 3'b011,
    WRTE = 3'b100,
    READ = 3'b101,
    BTRM = 3'b110,
    NOOP = 3'b111
  } sdram_cmd_e;

  typedef enum logic [1:0] {
    SCH_WAIT   = 2'd0,           // Second stroke, always NOOP
    SCH_DECIDE = 2'd1,
    SCH_DONE   = 2'd2            // Transfer issued, waiting on arbiter
  } sched_state_e;

  typedef struct packed {
    logic [`SDRAM_ADDR_W-1:0] addr;
    logic                     we;
    logic [`SDRAM_DM_W-1:0]   dm;
  } mem_req_t;

  typedef struct packed {
    logic [`SDRAM_BANK_W-1:0] bank;
    logic [`SDRAM_ROW_W-1:0]  row;
  } page_t;

  typedef struct packed {
    sdram_cmd_e               op;
    logic [`SDRAM_BANK_W-1:0] bank;
    logic [`SDRAM_ROW_W-1:0]  addr;
    logic [`SDRAM_DM_W-1:0]   dm;
  } sdram_cmd_t;

endpackage

/* sdram_port_arbiter.sv */
`timescale 1ns/10ps

module sdram_port_arbiter (
  input  logic               INPUT_CLK,
  input  logic               RST,
  input  logic               req_rand,
  input  logic               req_bulk,
  input  sdram_pkg::mem_req_t rand_req,
  input  sdram_pkg::mem_req_t bulk_req,
  input  logic               xfer_done,
  output logic               ack_rand,
  output logic               ack_bulk,
  output logic               sel_valid,
  output sdram_pkg::mem_req_t sel_req
);

  import sdram_pkg::*;

  logic idle;
  logic grant_bulk;
  logic grant_rand;
  logic sel_bulk;                // Port owning sel_req

  // Nothing held and both handshakes fully closed
  assign idle       = !sel_valid && !ack_rand && !ack_bulk;
  assign grant_bulk = idle && req_bulk;
  assign grant_rand = idle && !req_bulk && req_rand;

  always_ff @(posedge INPUT_CLK)
  begin
    if (RST)
    begin
      sel_valid <= 1'b0;
      sel_bulk  <= 1'b0;
      ack_rand  <= 1'b0;
      ack_bulk  <= 1'b0;
    end
    else
    begin
      if (grant_bulk || grant_rand)
      begin
        sel_valid <= 1'b1;
        sel_bulk  <= grant_bulk;
      end

      if (xfer_done)
      begin
        sel_valid <= 1'b0;
        if (sel_bulk)
          ack_bulk <= 1'b1;
        else
          ack_rand <= 1'b1;
      end

      if (ack_rand && !req_rand)
        ack_rand <= 1'b0;        // Phase 4
      if (ack_bulk && !req_bulk)
        ack_bulk <= 1'b0;
    end
  end

  // Payload held until the transfer is acked
  always_ff @(posedge INPUT_CLK)
  begin
    if (grant_bulk)
      sel_req <= bulk_req;
    else if (grant_rand)
      sel_req <= rand_req;
  end

endmodule

/* sdram_page_tracker.sv */
`timescale 1ns/10ps
`include "sdram_params.svh"

module sdram_page_tracker (
  input  logic                 INPUT_CLK,
  input  logic                 RST,
  input  logic                 refresh_toggle,
  input  sdram_pkg::sdram_cmd_t issued,
  input  sdram_pkg::mem_req_t  sel_req,
  output logic                 page_active,
  output logic                 page_hit,
  output logic                 refresh_pending,
  output sdram_pkg::page_t     open_page
);

  import sdram_pkg::*;

  logic  refresh_ack;            // Toggle level at last ARSR
  page_t req_page;

  assign req_page.bank = sel_req.addr[`SDRAM_BANK_LSB +: `SDRAM_BANK_W];
  assign req_page.row  = sel_req.addr[`SDRAM_ROW_LSB +: `SDRAM_ROW_W];

  assign page_hit        = page_active && (req_page == open_page);
  assign refresh_pending = refresh_toggle ^ refresh_ack;

  always_ff @(posedge INPUT_CLK)
  begin
    if (RST)
    begin
      page_active <= 1'b0;
      refresh_ack <= refresh_toggle; // No refresh owed out of reset
    end
    else
    begin
      case (issued.op)
        ACTV: page_active <= 1'b1;
        PRCH: page_active <= 1'b0;
        ARSR: refresh_ack <= refresh_toggle;
        default: ;
      endcase
    end
  end

  always_ff @(posedge INPUT_CLK)
  begin
    if (issued.op == ACTV)
    begin
      open_page.bank <= issued.bank;
      open_page.row  <= issued.addr;
    end
  end

endmodule

/* sdram_timing_counter.sv */
`timescale 1ns/10ps
`include "sdram_params.svh"

module sdram_timing_counter (
  input  logic                 INPUT_CLK,
  input  logic                 RST,
  input  sdram_pkg::sdram_cmd_t issued,
  output logic                 cmd_ready,
  output logic                 ras_ok
);

  import sdram_pkg::*;

  localparam int CNT_W = $clog2(`SDRAM_T_RFC + 1);
  localparam int RAS_W = $clog2(`SDRAM_T_RAS + 1);

  logic [CNT_W-1:0] gap_cnt;     // Spacing after last command
  logic [RAS_W-1:0] ras_cnt;     // ACTV to PRCH minimum

  assign cmd_ready = (gap_cnt == '0);
  assign ras_ok    = (ras_cnt == '0);

  always_ff @(posedge INPUT_CLK)
  begin
    if (RST)
      gap_cnt <= CNT_W'(`SDRAM_T_RP);
    else
    begin
      case (issued.op)
        NOOP:        gap_cnt <= cmd_ready ? gap_cnt : gap_cnt - 1'b1;
        ACTV:        gap_cnt <= CNT_W'(`SDRAM_T_RCD);
        READ, WRTE:  gap_cnt <= CNT_W'(`SDRAM_T_RW);
        ARSR:        gap_cnt <= CNT_W'(`SDRAM_T_RFC);
        default:     gap_cnt <= CNT_W'(`SDRAM_T_RP); // PRCH
      endcase
    end
  end

  always_ff @(posedge INPUT_CLK)
  begin
    if (RST)
      ras_cnt <= '0;
    else if (issued.op == ACTV)
      ras_cnt <= RAS_W'(`SDRAM_T_RAS);
    else if (!ras_ok)
      ras_cnt <= ras_cnt - 1'b1;
  end

endmodule

/* sdram_cmd_scheduler.sv */
`timescale 1ns/10ps
`include "sdram_params.svh"

module sdram_cmd_scheduler (
  input  logic                 INPUT_CLK,
  input  logic                 RST,
  input  logic                 sel_valid,
  input  sdram_pkg::mem_req_t  sel_req,
  input  logic                 page_active,
  input  logic                 page_hit,
  input  logic                 refresh_pending,
  input  sdram_pkg::page_t     open_page,
  input  logic                 cmd_ready,
  input  logic                 ras_ok,
  output sdram_pkg::sdram_cmd_t issued,
  output logic                 xfer_done
);

  import sdram_pkg::*;

  sched_state_e state;
  sdram_cmd_t   nxt_cmd;
  logic         nxt_xfer;
  logic [`SDRAM_ROW_W-1:0] col_addr;

  // Column goes out shifted by one, upper bits zero
  assign col_addr = `SDRAM_ROW_W'({sel_req.addr[`SDRAM_COL_W-1:0], 1'b0});

  // ----------------------------------------------------------------------
  // Command choice, by priority
  // ----------------------------------------------------------------------
  always_comb
  begin
    nxt_cmd.op   = NOOP;
    nxt_cmd.bank = open_page.bank;
    nxt_cmd.addr = `SDRAM_PRCH_ALL;
    nxt_cmd.dm   = '0;
    nxt_xfer     = 1'b0;

    if ((state == SCH_DECIDE) && cmd_ready)
    begin
      if (refresh_pending && page_active)
      begin
        if (ras_ok)
          nxt_cmd.op = PRCH;     // Close page before refresh
      end
      else if (refresh_pending)
        nxt_cmd.op = ARSR;
      else if (sel_valid && page_hit)
      begin
        nxt_cmd.op   = sel_req.we ? WRTE : READ;
        nxt_cmd.addr = col_addr;
        nxt_cmd.dm   = sel_req.we ? sel_req.dm : '0;
        nxt_xfer     = 1'b1;
      end
      else if (sel_valid && page_active)
      begin
        if (ras_ok)
          nxt_cmd.op = PRCH;     // Page miss
      end
      else if (sel_valid)
      begin
        nxt_cmd.op   = ACTV;
        nxt_cmd.bank = sel_req.addr[`SDRAM_BANK_LSB +: `SDRAM_BANK_W];
        nxt_cmd.addr = sel_req.addr[`SDRAM_ROW_LSB +: `SDRAM_ROW_W];
      end
    end
  end

  // ----------------------------------------------------------------------
  // State and command register
  // ----------------------------------------------------------------------
  always_ff @(posedge INPUT_CLK)
  begin
    if (RST)
    begin
      state     <= SCH_WAIT;
      issued    <= '{op: NOOP, bank: '0, addr: '0, dm: '0};
      xfer_done <= 1'b0;
    end
    else
    begin
      issued    <= nxt_cmd;
      xfer_done <= nxt_xfer;     // Lines up with READ/WRTE on issued

      case (state)
        SCH_WAIT:
          state <= SCH_DECIDE;
        SCH_DECIDE:
        begin
          if (nxt_xfer)
            state <= SCH_DONE;
          else if (nxt_cmd.op != NOOP)
            state <= SCH_WAIT;
        end
        SCH_DONE:
        begin
          if (!sel_valid)
            state <= SCH_DECIDE;
        end
        default:
          state <= SCH_WAIT;
      endcase
    end
  end

endmodule

/* sdram_ctrl_top.sv */
`timescale 1ns/10ps

module sdram_ctrl_top (
  input  logic                 INPUT_CLK,
  input  logic                 RST,
  input  logic                 req_rand,
  input  logic                 req_bulk,
  input  sdram_pkg::mem_req_t  rand_req,
  input  sdram_pkg::mem_req_t  bulk_req,
  output logic                 ack_rand,
  output logic                 ack_bulk,
  input  logic                 refresh_toggle,
  output sdram_pkg::sdram_cmd_t sdram_cmd
);

  import sdram_pkg::*;

  logic       sel_valid;
  mem_req_t   sel_req;
  logic       xfer_done;
  sdram_cmd_t issued;
  logic       page_active;
  logic       page_hit;
  logic       refresh_pending;
  page_t      open_page;
  logic       cmd_ready;
  logic       ras_ok;

  assign sdram_cmd = issued;     // Already registered

  sdram_port_arbiter u_arbiter (
    .INPUT_CLK (INPUT_CLK),
    .RST       (RST),
    .req_rand  (req_rand),
    .req_bulk  (req_bulk),
    .rand_req  (rand_req),
    .bulk_req  (bulk_req),
    .xfer_done (xfer_done),
    .ack_rand  (ack_rand),
    .ack_bulk  (ack_bulk),
    .sel_valid (sel_valid),
    .sel_req   (sel_req)
  );

  sdram_page_tracker u_tracker (
    .INPUT_CLK       (INPUT_CLK),
    .RST             (RST),
    .refresh_toggle  (refresh_toggle),
    .issued          (issued),
    .sel_req         (sel_req),
    .page_active     (page_active),
    .page_hit        (page_hit),
    .refresh_pending (refresh_pending),
    .open_page       (open_page)
  );

  sdram_timing_counter u_timing (
    .INPUT_CLK (INPUT_CLK),
    .RST       (RST),
    .issued    (issued),
    .cmd_ready (cmd_ready),
    .ras_ok    (ras_ok)
  );

  sdram_cmd_scheduler u_sched (
    .INPUT_CLK       (INPUT_CLK),
    .RST             (RST),
    .sel_valid       (sel_valid),
    .sel_req         (sel_req),
    .page_active     (page_active),
    .page_hit        (page_hit),
    .refresh_pending (refresh_pending),
    .open_page       (open_page),
    .cmd_ready       (cmd_ready),
    .ras_ok          (ras_ok),
    .issued          (issued),
    .xfer_done       (xfer_done)
  );

endmodule

/* tb_sdram_ctrl.sv */
`timescale 1ns/10ps
`include "sdram_params.svh"

module tb_sdram_ctrl;

  import sdram_pkg::*;

  localparam int MAX_WAIT = 400;  // Cycles allowed per wait loop
  localparam int N_ROWS   = 10;

  typedef struct packed {
    logic [1:0]               port;     // 0 rand, 1 bulk, 2 both
    logic [`SDRAM_ROW_W-1:0]  row;
    logic [`SDRAM_BANK_W-1:0] bank;
    logic                     we;
    logic [`SDRAM_DM_W-1:0]   dm;
    logic [1:0]               refresh;  // 1 toggle first, 2 toggle after ACTV
  } stim_row_t;

  stim_row_t rows [N_ROWS] = '{
    '{2'd0, 14'h0123, 3'd2, 1'b0, 4'h0, 2'd0},  // From idle
    '{2'd0, 14'h0123, 3'd2, 1'b1, 4'h5, 2'd0},  // Hit
    '{2'd1, 14'h0123, 3'd2, 1'b0, 4'h0, 2'd0},
    '{2'd0, 14'h0456, 3'd2, 1'b1, 4'hA, 2'd0},  // Conflict
    '{2'd1, 14'h0456, 3'd2, 1'b0, 4'h0, 2'd1},  // Refresh, page open
    '{2'd0, 14'h3FFF, 3'd7, 1'b1, 4'hF, 2'd1},
    '{2'd2, 14'h0010, 3'd1, 1'b1, 4'h3, 2'd0},  // Contention
    '{2'd2, 14'h0200, 3'd4, 1'b0, 4'h6, 2'd0},
    '{2'd1, 14'h0200, 3'd5, 1'b0, 4'h0, 2'd2},  // Bank miss, refresh right after ACTV
    '{2'd0, 14'h0200, 3'd5, 1'b1, 4'h9, 2'd1}
  };

  logic       INPUT_CLK;
  logic       RST;
  logic       req_rand;
  logic       req_bulk;
  mem_req_t   rand_req;
  mem_req_t   bulk_req;
  logic       ack_rand;
  logic       ack_bulk;
  logic       refresh_toggle;
  sdram_cmd_t sdram_cmd;

  // Reference model state
  int         cyc;
  bit         mon_on;
  bit         model_active;
  page_t      model_page;
  int         last_cmd_cycle;
  sdram_cmd_e last_op;
  int         last_actv_cycle;
  int         arsr_count;
  int         toggle_count;
  int         pa_count;         // ACTV plus PRCH seen
  int         acc_cycle;
  sdram_cmd_t acc_cmd;
  page_t      acc_page;
  page_t      want_page [2];
  bit         want_valid [2];
  int         ack_count [2];
  int         exp_acks [2];
  int         ack_order [2];
  int         order_seq;
  logic       prev_ack [2];
  logic [31:0] rng;

  sdram_ctrl_top UUT (
    .INPUT_CLK      (INPUT_CLK),
    .RST            (RST),
    .req_rand       (req_rand),
    .req_bulk       (req_bulk),
    .rand_req       (rand_req),
    .bulk_req       (bulk_req),
    .ack_rand       (ack_rand),
    .ack_bulk       (ack_bulk),
    .refresh_toggle (refresh_toggle),
    .sdram_cmd      (sdram_cmd)
  );

  initial
  begin
    INPUT_CLK = 1'b0;
    forever #20 INPUT_CLK = ~INPUT_CLK;
  end

  always @(posedge INPUT_CLK)
    cyc = cyc + 1;

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------
  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("MISMATCH %s got %h expected %h", name, got, exp);
      $display("RESULT: FAIL");
      $fatal(1);
    end
  endtask

  task automatic fail_timeout(input string what);
    $display("Timed out waiting for %s", what);
    $display("RESULT: FAIL");
    $fatal(1);
  endtask

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic int spacing_of(input sdram_cmd_e op);
    case (op)
      ACTV:       return `SDRAM_T_RCD;
      READ, WRTE: return `SDRAM_T_RW;
      ARSR:       return `SDRAM_T_RFC;
      default:    return `SDRAM_T_RP;
    endcase
  endfunction

  function automatic mem_req_t make_req(input stim_row_t s, input logic [8:0] col,
                                        input logic we);
    mem_req_t r;
    r = '0;
    r.addr[`SDRAM_ROW_LSB +: `SDRAM_ROW_W]   = s.row;
    r.addr[`SDRAM_BANK_LSB +: `SDRAM_BANK_W] = s.bank;
    r.addr[`SDRAM_COL_W-1:0]                 = col;
    r.we = we;
    r.dm = s.dm;
    return r;
  endfunction

  // ----------------------------------------------------------------------
  // Command monitor
  // ----------------------------------------------------------------------
  always @(negedge INPUT_CLK)
  begin
    if (mon_on && sdram_cmd.op != NOOP)
    begin
      check("cmd spacing ok", cyc - last_cmd_cycle >= spacing_of(last_op), 1);
      case (sdram_cmd.op)
        ACTV:
        begin
          check("page idle at ACTV", model_active, 0);
          check("ACTV matches a request",
                (want_valid[0] && want_page[0] == {sdram_cmd.bank, sdram_cmd.addr}) ||
                (want_valid[1] && want_page[1] == {sdram_cmd.bank, sdram_cmd.addr}), 1);
          model_active    = 1'b1;
          model_page      = {sdram_cmd.bank, sdram_cmd.addr};
          last_actv_cycle = cyc;
          pa_count        = pa_count + 1;
        end
        PRCH:
        begin
          check("sdram_cmd.addr", sdram_cmd.addr, `SDRAM_PRCH_ALL);
          check("page open at PRCH", model_active, 1);
          check("tRAS ok", cyc - last_actv_cycle >= `SDRAM_T_RAS, 1);
          check("PRCH needed", (arsr_count < toggle_count) ||
                (want_valid[0] && want_page[0] != model_page) ||
                (want_valid[1] && want_page[1] != model_page), 1);
          model_active = 1'b0;
          pa_count     = pa_count + 1;
        end
        ARSR:
        begin
          check("page idle at ARSR", model_active, 0);
          check("ARSR owed", arsr_count < toggle_count, 1);
          arsr_count = arsr_count + 1;
        end
        READ, WRTE:
        begin
          check("page open at access", model_active, 1);
          check("refresh done before access", arsr_count, toggle_count);
          acc_cycle = cyc;
          acc_cmd   = sdram_cmd;
          acc_page  = model_page;
        end
        default:
          check("sdram_cmd.op", sdram_cmd.op, NOOP);
      endcase
      last_cmd_cycle = cyc;
      last_op        = sdram_cmd.op;
    end
    if (mon_on)
    begin
      if (ack_rand && !prev_ack[0])
        ack_count[0] = ack_count[0] + 1;
      if (ack_bulk && !prev_ack[1])
        ack_count[1] = ack_count[1] + 1;
    end
    prev_ack[0] = ack_rand;
    prev_ack[1] = ack_bulk;
  end

  // Four-phase requester on one port
  task automatic do_request(input bit bulk, input mem_req_t r);
    int   n;
    logic ack;
    page_t pg;
    pg.bank = r.addr[`SDRAM_BANK_LSB +: `SDRAM_BANK_W];
    pg.row  = r.addr[`SDRAM_ROW_LSB +: `SDRAM_ROW_W];
    @(posedge INPUT_CLK);
    want_page[bulk]  = pg;
    want_valid[bulk] = 1'b1;
    exp_acks[bulk]   = exp_acks[bulk] + 1;
    if (bulk)
    begin
      bulk_req <= r;
      req_bulk <= 1'b1;
    end
    else
    begin
      rand_req <= r;
      req_rand <= 1'b1;
    end
    n   = 0;
    ack = 1'b0;
    while (!ack)
    begin
      @(negedge INPUT_CLK);
      ack = bulk ? ack_bulk : ack_rand;
      n   = n + 1;
      if (!ack && n > MAX_WAIT)
        fail_timeout(bulk ? "ack_bulk to rise" : "ack_rand to rise");
    end
    check("ack one cycle after access", acc_cycle, cyc - 1);
    check("sdram_cmd.op", acc_cmd.op, r.we ? WRTE : READ);
    check("sdram_cmd.bank", acc_cmd.bank, pg.bank);
    check("open row", acc_page.row, pg.row);
    check("sdram_cmd.addr", acc_cmd.addr, {r.addr[`SDRAM_COL_W-1:0], 1'b0});
    if (r.we)
      check("sdram_cmd.dm", acc_cmd.dm, r.dm);
    ack_order[bulk]  = order_seq;
    order_seq        = order_seq + 1;
    want_valid[bulk] = 1'b0;
    // Req held one more cycle, ack has to stay up
    @(negedge INPUT_CLK);
    check(bulk ? "ack_bulk" : "ack_rand", bulk ? ack_bulk : ack_rand, 1);
    @(posedge INPUT_CLK);
    if (bulk)
      req_bulk <= 1'b0;
    else
      req_rand <= 1'b0;
    n = 0;
    while (ack)
    begin
      @(negedge INPUT_CLK);
      ack = bulk ? ack_bulk : ack_rand;
      n   = n + 1;
      if (ack && n > MAX_WAIT)
        fail_timeout(bulk ? "ack_bulk to fall" : "ack_rand to fall");
    end
  endtask

  // Toggle refresh in the cycle after the wanted page opens
  task automatic refresh_after_actv(input page_t pg);
    int n;
    n = 0;
    @(posedge INPUT_CLK);
    while (!(model_active && model_page == pg))
    begin
      @(posedge INPUT_CLK);
      n = n + 1;
      if (n > MAX_WAIT)
        fail_timeout("ACTV to the requested page");
    end
    refresh_toggle <= ~refresh_toggle;
    toggle_count = toggle_count + 1;
  endtask

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------
  initial
  begin : main
    mem_req_t r0;
    mem_req_t r1;
    bit       hit_exp;
    int       pa_before;
    RST            = 1'b1;
    req_rand       = 1'b0;
    req_bulk       = 1'b0;
    rand_req       = '0;
    bulk_req       = '0;
    refresh_toggle = 1'b0;
    cyc            = 0;
    mon_on         = 1'b0;
    model_active   = 1'b0;
    model_page     = '0;
    arsr_count     = 0;
    toggle_count   = 0;
    pa_count       = 0;
    acc_cycle      = -1;
    acc_cmd        = '0;
    acc_page       = '0;
    order_seq      = 0;
    rng            = 32'd73978;
    for (int p = 0; p < 2; p++)
    begin
      want_valid[p] = 1'b0;
      want_page[p]  = '0;
      ack_count[p]  = 0;
      exp_acks[p]   = 0;
      ack_order[p]  = 0;
      prev_ack[p]   = 1'b0;
    end

    repeat (5)
    begin
      @(negedge INPUT_CLK);
      check("sdram_cmd.op", sdram_cmd.op, NOOP);
      check("ack_rand", ack_rand, 0);
      check("ack_bulk", ack_bulk, 0);
    end
    @(posedge INPUT_CLK);
    RST <= 1'b0;
    @(negedge INPUT_CLK);
    last_cmd_cycle  = cyc;    // Reset spaced like a PRCH
    last_op         = PRCH;
    last_actv_cycle = -100;
    mon_on          = 1'b1;
    repeat (2)
    begin
      @(negedge INPUT_CLK);
      check("sdram_cmd.op", sdram_cmd.op, NOOP);
      check("ack_rand", ack_rand, 0);
      check("ack_bulk", ack_bulk, 0);
    end

    for (int i = 0; i < N_ROWS; i++)
    begin
      if (rows[i].refresh == 2'd1)
      begin
        @(posedge INPUT_CLK);
        refresh_toggle <= ~refresh_toggle;
        toggle_count = toggle_count + 1;
      end
      rng = xorshift(rng);
      r0  = make_req(rows[i], rng[8:0], rows[i].we);
      hit_exp = model_active && !rows[i].refresh &&
                (model_page == {rows[i].bank, rows[i].row});
      pa_before = pa_count;
      if (rows[i].port == 2'd2)
      begin
        rng = xorshift(rng);
        r1  = make_req(rows[i], rng[8:0], !rows[i].we);
        fork
          do_request(1'b1, r0);
          do_request(1'b0, r1);
        join
        check("bulk served first", ack_order[1] < ack_order[0], 1);
      end
      else if (rows[i].refresh == 2'd2)
      begin
        fork
          do_request(rows[i].port[0], r0);
          refresh_after_actv({rows[i].bank, rows[i].row});
        join
      end
      else
        do_request(rows[i].port[0], r0);
      if (hit_exp)
        check("ACTV/PRCH on page hit", pa_count - pa_before, 0);
    end

    repeat (4) @(negedge INPUT_CLK);
    check("ARSR count", arsr_count, toggle_count);
    check("ack_rand count", ack_count[0], exp_acks[0]);
    check("ack_bulk count", ack_count[1], exp_acks[1]);
    $display("RESULT: PASS");
    $finish;
  end

endmodule

/* compile.f */
+incdir+.
sdram_pkg.sv
sdram_port_arbiter.sv
sdram_page_tracker.sv
sdram_timing_counter.sv
sdram_cmd_scheduler.sv
sdram_ctrl_top.sv
tb_sdram_ctrl.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the SDRAM controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal \
  --top-module tb_sdram_ctrl \
  -f compile.f \
  -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
fi

if grep -q "^RESULT: PASS$" "$LOG"; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed"
  exit 1
fi
